//--- decode_stage.f
rtl/decode_pkg.sv
rtl/instr_classifier.sv
rtl/imm_gen.sv
rtl/reg_lock_queue.sv
rtl/decode_stage.sv
test/tb_clock.sv
test/decode_props.sv
test/decode_tb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - files:
      - rtl/decode_pkg.sv
      - rtl/instr_classifier.sv
      - rtl/imm_gen.sv
      - rtl/reg_lock_queue.sv
      - rtl/decode_stage.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/decode_props.sv
      - test/decode_tb.sv

//--- test/decode_tb.sv
/* Fetch is modelled as holding its word while stall or hazard is seen at the falling edge
   The register file is a fixed random array read asynchronously, x0 reads zero */
module decode_tb
    import decode_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED        = 13163;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 400;                           // Longest test
    localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES + 600;  // Reset and drain margin
    localparam int ACCEPT_WAIT = 20;

    // Operations by funct3
    localparam op_e BRANCH_OPS [8] = '{BEQ, BNE, INVALID, INVALID, BLT, BGE, BLTU, BGEU};
    localparam op_e LOAD_OPS [8]   = '{LB, LH, LW, INVALID, LBU, LHU, INVALID, INVALID};
    localparam op_e STORE_OPS [8]  = '{SB, SH, SW, INVALID, INVALID, INVALID, INVALID, INVALID};
    localparam op_e ALU_OPS [8]    = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};

    // Last two are SYSTEM and MISC-MEM, both outside the decoded set
    localparam logic [6:0] OPCODES [11] = '{OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JALR,
        OPC_JAL, OPC_OP_IMM, OPC_OP, OPC_LUI, OPC_AUIPC, 7'b1110011, 7'b0001111};
    localparam logic [6:0] FORMAT_OPCODES [8] = '{OPC_OP, OPC_OP_IMM, OPC_STORE,
        OPC_BRANCH, OPC_LUI, OPC_JAL, OPC_AUIPC, 7'b1111111};
    localparam logic [31:0] SYSTEM_WORDS [5] = '{32'h0000_0073, 32'h0010_0073,
        32'h3020_0073, 32'h1050_0073, 32'h0ff0_000f};       // ECALL EBREAK MRET WFI FENCE

    logic              clk;
    logic              reset;
    logic              stall;
    fetch_t            fetch;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [REG_AW-1:0] rd;
    issue_t            issue;
    logic              hazard;
    logic [XLEN-1:0]   regs [32];

    // Cycle model state
    logic [31:0]       m_instr_r;
    logic              m_hazard_r = 1'b0;
    logic [REG_AW-1:0] m_rd [2]    = '{default: '0};
    logic              m_store [2] = '{default: 1'b0};
    issue_t            m_issue     = '0;
    issue_t            prev_issue;
    logic [REG_AW-1:0] prev_rd;
    logic              held = 1'b0;                      // Last edge was stalled
    int                errors = 0;
    int                checks = 0;
    int                bad_tests = 0;
    int                cycles = 0;
    int                hazard_seen;                      // Hazard cycles of the last word

    tb_clock u_clock (
        .clk_o (clk)
    );

    decode_stage uut (
        .clk        (clk),
        .reset      (reset),
        .stall_i    (stall),
        .fetch_i    (fetch),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_o       (rd),
        .issue_o    (issue),
        .hazard_o   (hazard)
    );

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    //////////////////////////////
    // Reference decode
    //////////////////////////////

    function automatic op_e expect_op(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        if (w == NOP_WORD) return NOP;
        case (w[6:0])
            OPC_LUI:    return LUI;
            OPC_AUIPC:  return ADD;
            OPC_JAL:    return JAL;
            OPC_JALR:   return (f3 == 3'd0) ? JALR : INVALID;
            OPC_BRANCH: return BRANCH_OPS[f3];
            OPC_LOAD:   return LOAD_OPS[f3];
            OPC_STORE:  return STORE_OPS[f3];
            OPC_OP_IMM: begin
                if (f3 == 3'd1) return (f7 == 7'h00) ? SLL : INVALID;
                if (f3 == 3'd5) return (f7 == 7'h00) ? SRL : (f7 == 7'h20) ? SRA : INVALID;
                return ALU_OPS[f3];
            end
            OPC_OP: begin
                if (f7 == 7'h00) return ALU_OPS[f3];
                if (f7 == 7'h20 && f3 == 3'd0) return SUB;
                if (f7 == 7'h20 && f3 == 3'd5) return SRA;
                return INVALID;
            end
            default:    return INVALID;
        endcase
    endfunction

    function automatic format_e expect_fmt(input logic [31:0] w);
        case (w[6:0])
            OPC_OP_IMM, OPC_JALR, OPC_LOAD: return I_TYPE;
            OPC_STORE:                      return S_TYPE;
            OPC_BRANCH:                     return B_TYPE;
            OPC_LUI, OPC_AUIPC:             return U_TYPE;
            OPC_JAL:                        return J_TYPE;
            default:                        return R_TYPE;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] expect_imm(input logic [31:0] w, input format_e f);
        case (f)
            I_TYPE:  return {{20{w[31]}}, w[31:20]};
            S_TYPE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            B_TYPE:  return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            U_TYPE:  return {w[31:12], 12'b0};
            J_TYPE:  return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return '0;
        endcase
    endfunction

    //////////////////////////////
    // Checks and model step
    //////////////////////////////

    task automatic check_value(input string name, input string what,
                               input logic [255:0] expected, input logic [255:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("FAIL %s %s: expected %0h, actual %0h", name, what, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string name, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR %s: %s", name, msg);
        end
    endtask

    // Called at the falling edge, then advances the model over the coming rising edge
    task automatic check_and_step(input string name);
        logic [31:0]       cur;
        op_e               op;
        format_e           fmt;
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic              haz;
        issue_t            nxt;
        cur = m_hazard_r ? m_instr_r : fetch.instr.raw;
        op  = expect_op(cur);
        fmt = expect_fmt(cur);
        imm = expect_imm(cur, fmt);
        rs1 = cur[19:15];
        rs2 = cur[24:20];
        haz = ((m_store[0] || m_store[1]) && (op inside {LB, LH, LW, LBU, LHU, SB, SH, SW}))
              || (m_rd[0] != '0 && (m_rd[0] == rs1 || m_rd[0] == rs2));
        check_value(name, "rs1_addr", rs1, rs1_addr);
        check_value(name, "rs2_addr", rs2, rs2_addr);
        check_value(name, "hazard", haz, hazard);
        check_value(name, "rd", m_rd[1], rd);
        check_value(name, "issue", m_issue, issue);
        if (held) begin
            check_value(name, "issue under stall", prev_issue, issue);
            check_value(name, "rd under stall", prev_rd, rd);
        end
        if (hazard) hazard_seen++;
        nxt     = '0;                                    // Bubble by default
        nxt.op  = NOP;
        nxt.tag = fetch.tag;
        if (!haz) begin
            nxt.first_op  = (fmt inside {U_TYPE, J_TYPE}) ? fetch.pc : regs[rs1];
            nxt.second_op = (fmt inside {R_TYPE, B_TYPE}) ? regs[rs2] : imm;
            nxt.third_op  = (fmt == S_TYPE) ? regs[rs2] : imm;
            nxt.pc        = fetch.pc;
            nxt.instr.raw = cur;
            nxt.op        = op;
            nxt.exception = (op == INVALID);
        end
        prev_issue = issue;
        prev_rd    = rd;
        held       = stall && !reset;
        m_instr_r  = cur;
        m_hazard_r = reset ? 1'b0 : haz;
        if (reset) begin
            m_issue = '0;
            m_rd    = '{default: '0};
            m_store = '{default: 1'b0};
        end else if (!stall) begin
            m_issue    = nxt;
            m_rd[1]    = m_rd[0];
            m_store[1] = m_store[0];
            m_rd[0]    = haz ? '0 : cur[11:7];
            m_store[0] = !haz && (op inside {SB, SH, SW});
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // Presents a word and keeps it until the stage takes it
    task automatic send_word(input string name, input logic [31:0] word, input int stall_pct);
        fetch_t f;
        int     waited;
        logic   accepted;
        f.instr.raw = word;
        f.pc        = $urandom() & 32'hffff_fffc;
        f.tag       = 3'($urandom_range(7));
        hazard_seen = 0;
        waited      = 0;
        accepted    = 1'b0;
        while (!accepted && waited < ACCEPT_WAIT) begin
            @(posedge clk);
            fetch <= f;
            stall <= ($urandom_range(99) < stall_pct);
            @(negedge clk);
            check_and_step(name);
            accepted = !stall && !hazard;
            waited++;
        end
        check_true(accepted, name, $sformatf("word %h was never accepted", word));
    endtask

    function automatic logic [31:0] make_word(input logic [6:0] opc);
        logic [31:0] w;
        w      = $urandom();
        w[6:0] = opc;
        case ($urandom_range(9))                         // Bias towards legal funct7
            0, 1, 2, 3, 4, 5: w[31:25] = 7'h00;
            6, 7, 8:          w[31:25] = 7'h20;
            default: ;
        endcase
        return w;
    endfunction

    function automatic logic [31:0] any_word();
        int pick;
        pick = $urandom_range(15);
        if (pick == 0) return NOP_WORD;
        if (pick == 1) return $urandom();                // Garbage
        if (pick == 2) return SYSTEM_WORDS[$urandom_range(4)];
        return make_word(OPCODES[$urandom_range(10)]);
    endfunction

    function automatic logic [31:0] quiet_word();
        logic [31:0] w;
        w        = make_word(OPC_OP_IMM);
        w[24:15] = '0;                                   // Reads only x0
        return w;
    endfunction

    task automatic end_test(input string name, input int start);
        if (errors != start) bad_tests++;
        $display("[%s] finished with %0d mismatches", name, errors - start);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("ERROR timeout: run did not end within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    initial begin : main
        logic [31:0]       w;
        logic [REG_AW-1:0] r;
        int                start;
        void'($urandom(SEED));
        foreach (regs[k]) regs[k] = (k == 0) ? '0 : $urandom();
        reset           = 1'b1;
        stall           = 1'b0;
        fetch.instr.raw = NOP_WORD;
        fetch.pc        = '0;
        fetch.tag       = '0;

        start = errors;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i == 7) reset <= 1'b0;
            @(negedge clk);
            check_and_step("reset");
            check_value("reset", "issue in reset", '0, issue);
            check_value("reset", "rd in reset", '0, rd);
        end
        repeat (2) send_word("reset", NOP_WORD, 0);
        end_test("reset", start);

        start = errors;
        repeat (150) begin
            w        = any_word();
            w[24:15] = '0;                               // Sources at x0
            send_word("decode", w, 0);
        end
        end_test("decode", start);

        start = errors;
        foreach (FORMAT_OPCODES[k]) begin
            repeat (20) send_word("operands", make_word(FORMAT_OPCODES[k]), 0);
        end
        end_test("operands", start);

        start = errors;
        repeat (30) begin
            r        = REG_AW'($urandom_range(31, 1));
            w        = make_word(OPC_OP_IMM);
            w[11:7]  = r;
            send_word("raw hazard", w, 0);
            w = make_word(OPC_OP);
            if ($urandom_range(1)) w[19:15] = r;
            else w[24:20] = r;
            send_word("raw hazard", w, 0);
            check_true(hazard_seen > 0, "raw hazard", "no hazard on a read of a pending rd");
        end
        end_test("raw hazard", start);

        start = errors;
        repeat (20) begin
            for (int mem = 1; mem >= 0; mem--) begin
                w          = make_word(OPC_STORE);
                w[14:12]   = 3'($urandom_range(2));
                send_word("store hazard", w, 0);
                if ($urandom_range(1)) send_word("store hazard", quiet_word(), 0);
                w          = mem ? make_word(OPC_LOAD) : quiet_word();
                w[14:12]   = mem ? 3'($urandom_range(2)) : w[14:12];
                send_word("store hazard", w, 0);
                if (mem) check_true(hazard_seen > 0, "store hazard", "load after store ran on");
                else check_true(hazard_seen == 0, "store hazard", "ALU word after store held");
            end
        end
        end_test("store hazard", start);

        start = errors;
        repeat (100) send_word("stall", any_word(), 30);
        repeat (2) send_word("stall", NOP_WORD, 0);
        end_test("stall", start);

        $display("summary: %0d tests, %0d bad, %0d checks, %0d mismatches, %0d property errors",
                 NUM_TESTS, bad_tests, checks, errors, uut.u_props.fail_count);
        if (errors == 0 && uut.u_props.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- test/decode_props.sv
/* Bound to decode_stage; every check is off while reset is high */
module decode_props
    import decode_pkg::*;
(
    input logic   clk,
    input logic   reset,
    input logic   stall_i,
    input logic   hazard_o,
    input issue_t issue_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;         // Failed assertions so far

    exception_is_invalid: assert property (
        @(posedge clk) disable iff (reset) issue_o.exception |-> issue_o.op == INVALID
    ) else begin
        fail_count++;
        $error("exception flag raised on an operation other than INVALID");
    end

    hazard_gives_bubble: assert property (
        @(posedge clk) disable iff (reset) (hazard_o && !stall_i) |=> issue_o.op == NOP
    ) else begin
        fail_count++;
        $error("hazard without stall was not followed by a NOP issue");
    end

    stall_holds_issue: assert property (
        @(posedge clk) disable iff (reset) stall_i |=> $stable(issue_o)
    ) else begin
        fail_count++;
        $error("issue bundle changed while the stage was stalled");
    end

endmodule

bind decode_stage decode_props u_props (
    .clk      (clk),
    .reset    (reset),
    .stall_i  (stall_i),
    .hazard_o (hazard_o),
    .issue_o  (issue_o)
);

//--- test/tb_clock.sv
/* Free-running clock that starts low, 100 ns period */
module tb_clock (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;      // First rising edge at 50 ns
    end

endmodule

//--- rtl/decode_stage.sv
/* Fetch must hold its word, PC and tag while hazard_o is high
   Register file read is asynchronous and addressed from the current word */
module decode_stage
    import decode_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              stall_i,      // Later stage busy
    input  fetch_t            fetch_i,
    input  logic [XLEN-1:0]   rs1_data_i,
    input  logic [XLEN-1:0]   rs2_data_i,
    output logic [REG_AW-1:0] rs1_addr_o,
    output logic [REG_AW-1:0] rs2_addr_o,
    output logic [REG_AW-1:0] rd_o,         // Destination two issues back
    output issue_t            issue_o,
    output logic              hazard_o      // Fetch holds while high
);

    instr_u          instr;
    instr_u          instr_r;
    logic            hazard_r;
    op_e             op;
    format_e         fmt;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] first_op;
    logic [XLEN-1:0] second_op;
    logic [XLEN-1:0] third_op;
    issue_t          issue_d;

    //////////////////////////////
    // Replay of a held word
    //////////////////////////////

    assign instr = hazard_r ? instr_r : fetch_i.instr;

    always_ff @(posedge clk) begin
        instr_r <= instr;                   // Loads on stalled cycles too
        if (reset) begin
            hazard_r <= 1'b0;
        end else begin
            hazard_r <= hazard_o;
        end
    end

    assign rs1_addr_o = instr.r.rs1;
    assign rs2_addr_o = instr.r.rs2;

    instr_classifier u_classifier (
        .instr_i  (instr),
        .op_o     (op),
        .format_o (fmt)
    );

    imm_gen u_imm_gen (
        .instr_i  (instr),
        .format_i (fmt),
        .imm_o    (imm)
    );

    reg_lock_queue u_lock_queue (
        .clk      (clk),
        .reset    (reset),
        .stall_i  (stall_i),
        .instr_i  (instr),
        .op_i     (op),
        .hazard_o (hazard_o),
        .rd_o     (rd_o)
    );

    //////////////////////////////
    // Operand select
    //////////////////////////////

    assign first_op  = (fmt == U_TYPE || fmt == J_TYPE) ? fetch_i.pc : rs1_data_i;
    assign second_op = (fmt == R_TYPE || fmt == B_TYPE) ? rs2_data_i : imm;
    assign third_op  = (fmt == S_TYPE) ? rs2_data_i : imm;

    always_comb begin
        issue_d     = '0;                   // Bubble unless the word issues
        issue_d.op  = NOP;
        issue_d.tag = fetch_i.tag;
        if (!hazard_o) begin
            issue_d.first_op  = first_op;
            issue_d.second_op = second_op;
            issue_d.third_op  = third_op;
            issue_d.pc        = fetch_i.pc;
            issue_d.instr     = instr;
            issue_d.op        = op;
            issue_d.exception = (op == INVALID);
        end
    end

    //////////////////////////////
    // Issue register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_o <= '0;                  // NOP encodes as zero
        end else if (!stall_i) begin
            issue_o <= issue_d;
        end
    end

endmodule

//--- rtl/reg_lock_queue.sv
/* Destination field enters for every word, stores and branches included
   Hazard output is combinational from the current word and queue state */
module reg_lock_queue
    import decode_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              stall_i,
    input  instr_u            instr_i,
    input  op_e               op_i,
    output logic              hazard_o,
    output logic [REG_AW-1:0] rd_o
);

    typedef struct packed {
        logic [REG_AW-1:0] rd;
        logic              store;
    } lock_entry_t;

    lock_entry_t lock_q [2];             // Entry 0 is the newest
    lock_entry_t entry_in;
    logic        is_store;
    logic        mem_hazard;
    logic        reg_hazard;

    assign is_store = (op_i == SB) || (op_i == SH) || (op_i == SW);

    always_comb begin
        entry_in = '0;                   // Bubble locks nothing
        if (!hazard_o) begin
            entry_in.rd    = instr_i.r.rd;
            entry_in.store = is_store;
        end
    end

    //////////////////////////////
    // Queue
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            lock_q[0] <= '0;
            lock_q[1] <= '0;
        end else if (!stall_i) begin
            lock_q[0] <= entry_in;
            lock_q[1] <= lock_q[0];
        end
    end

    assign rd_o = lock_q[1].rd;

    //////////////////////////////
    // Hazard
    //////////////////////////////

    assign mem_hazard = (lock_q[0].store || lock_q[1].store)
                        && (unit_e'(op_i[5:3]) == MEMORY_UNIT);

    assign reg_hazard = (lock_q[0].rd != '0)
                        && ((lock_q[0].rd == instr_i.r.rs1) || (lock_q[0].rd == instr_i.r.rs2));

    assign hazard_o = mem_hazard || reg_hazard;

endmodule

//--- rtl/imm_gen.sv
/* Combinational; R format yields a zero immediate
   The sign always comes from instruction bit 31 */
module imm_gen
    import decode_pkg::*;
(
    input  instr_u          instr_i,
    input  format_e         format_i,
    output logic [XLEN-1:0] imm_o
);

    logic sign;

    assign sign = instr_i.raw[31];

    always_comb begin
        case (format_i)
            I_TYPE: imm_o = {{20{sign}}, instr_i.i.imm_11_0};
            S_TYPE: imm_o = {{20{sign}},
                             instr_i.s.imm_11_5,
                             instr_i.s.imm_4_0};
            B_TYPE: imm_o = {{20{sign}},
                             instr_i.b.imm_11,
                             instr_i.b.imm_10_5,
                             instr_i.b.imm_4_1,
                             1'b0};               // Halfword aligned offset
            U_TYPE: imm_o = {instr_i.u.imm_31_12, 12'b0};
            J_TYPE: imm_o = {{12{sign}},
                             instr_i.j.imm_19_12,
                             instr_i.j.imm_11,
                             instr_i.j.imm_10_1,
                             1'b0};               // Halfword aligned offset
            default: imm_o = '0;                  // R format has no immediate
        endcase
    end

    // Bit 12 of B and bit 20 of J sit at instruction bit 31,
    // so the replicated sign above already covers them

endmodule

//--- rtl/instr_classifier.sv
/* Combinational; the canonical NOP word is the only word that decodes as NOP
   Format comes from the opcode alone, so unknown opcodes give R format */
module instr_classifier
    import decode_pkg::*;
(
    input  instr_u  instr_i,
    output op_e     op_o,
    output format_e format_o
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;

    assign opcode = instr_i.r.opcode;
    assign funct7 = instr_i.r.funct7;
    assign funct3 = instr_i.r.funct3;

    //////////////////////////////
    // Operation
    //////////////////////////////

    always_comb begin
        op_o = INVALID;                              // Anything not matched below
        if (instr_i.raw == NOP_WORD) begin
            op_o = NOP;
        end else begin
            case (opcode)
                OPC_LUI:   op_o = LUI;
                OPC_AUIPC: op_o = ADD;               // PC plus upper immediate
                OPC_JAL:   op_o = JAL;
                OPC_JALR:  op_o = (funct3 == 3'b000) ? JALR : INVALID;
                OPC_BRANCH: case (funct3)
                    3'b000:  op_o = BEQ;
                    3'b001:  op_o = BNE;
                    3'b100:  op_o = BLT;
                    3'b101:  op_o = BGE;
                    3'b110:  op_o = BLTU;
                    3'b111:  op_o = BGEU;
                    default: op_o = INVALID;
                endcase
                OPC_LOAD: case (funct3)
                    3'b000:  op_o = LB;
                    3'b001:  op_o = LH;
                    3'b010:  op_o = LW;
                    3'b100:  op_o = LBU;
                    3'b101:  op_o = LHU;
                    default: op_o = INVALID;
                endcase
                OPC_STORE: case (funct3)
                    3'b000:  op_o = SB;
                    3'b001:  op_o = SH;
                    3'b010:  op_o = SW;
                    default: op_o = INVALID;
                endcase
                OPC_OP_IMM: case (funct3)
                    3'b000:  op_o = ADD;             // ADDI
                    3'b010:  op_o = SLT;
                    3'b011:  op_o = SLTU;
                    3'b100:  op_o = XOR;
                    3'b110:  op_o = OR;
                    3'b111:  op_o = AND;
                    3'b001:  op_o = (funct7 == F7_BASE) ? SLL : INVALID;
                    default: begin                   // SRLI and SRAI share funct3
                        if (funct7 == F7_BASE) begin
                            op_o = SRL;
                        end else if (funct7 == F7_ALT) begin
                            op_o = SRA;
                        end
                    end
                endcase
                OPC_OP: case ({funct7, funct3})
                    {F7_BASE, 3'b000}: op_o = ADD;
                    {F7_ALT,  3'b000}: op_o = SUB;
                    {F7_BASE, 3'b001}: op_o = SLL;
                    {F7_BASE, 3'b010}: op_o = SLT;
                    {F7_BASE, 3'b011}: op_o = SLTU;
                    {F7_BASE, 3'b100}: op_o = XOR;
                    {F7_BASE, 3'b101}: op_o = SRL;
                    {F7_ALT,  3'b101}: op_o = SRA;
                    {F7_BASE, 3'b110}: op_o = OR;
                    {F7_BASE, 3'b111}: op_o = AND;
                    default:           op_o = INVALID;
                endcase
                default: op_o = INVALID;
            endcase
        end
    end

    //////////////////////////////
    // Encoding format
    //////////////////////////////

    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_JALR, OPC_LOAD: format_o = I_TYPE;
            OPC_STORE:                      format_o = S_TYPE;
            OPC_BRANCH:                     format_o = B_TYPE;
            OPC_LUI, OPC_AUIPC:             format_o = U_TYPE;
            OPC_JAL:                        format_o = J_TYPE;
            default:                        format_o = R_TYPE;
        endcase
    end

endmodule

//--- rtl/decode_pkg.sv
/* RV32I base integer encodings only; CSR, system and fence words decode as INVALID
   Operation codes carry their execution unit in the upper three bits */
package decode_pkg;

    //////////////////////////////
    // Widths and encodings
    //////////////////////////////

    localparam int XLEN   = 32;          // Data and PC width
    localparam int REG_AW = 5;           // Register address width
    localparam int TAG_W  = 3;           // Instruction tag width

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;       // SUB, SRA and SRAI

    localparam logic [31:0] NOP_WORD = 32'h0000_0013;  // ADDI x0, x0, 0

    //////////////////////////////
    // Operation and format
    //////////////////////////////

    typedef enum logic [2:0] {
        ALU_UNIT    = 3'b000,
        SHIFT_UNIT  = 3'b001,
        BRANCH_UNIT = 3'b010,
        MEMORY_UNIT = 3'b011,
        NO_UNIT     = 3'b111            // Not executed, raises an exception
    } unit_e;

    typedef enum logic [5:0] {
        NOP     = 6'b000_000,
        ADD     = 6'b000_001,
        SUB     = 6'b000_010,
        SLT     = 6'b000_011,
        SLTU    = 6'b000_100,
        XOR     = 6'b000_101,
        OR      = 6'b000_110,
        AND     = 6'b000_111,
        LUI     = 6'b001_000,           // Passes the shifted immediate
        SLL     = 6'b001_001,
        SRL     = 6'b001_010,
        SRA     = 6'b001_011,
        JAL     = 6'b010_000,
        JALR    = 6'b010_001,
        BEQ     = 6'b010_010,
        BNE     = 6'b010_011,
        BLT     = 6'b010_100,
        BGE     = 6'b010_101,
        BLTU    = 6'b010_110,
        BGEU    = 6'b010_111,
        LB      = 6'b011_000,
        LH      = 6'b011_001,
        LW      = 6'b011_010,
        LBU     = 6'b011_011,
        LHU     = 6'b011_100,
        SB      = 6'b011_101,
        SH      = 6'b011_110,
        SW      = 6'b011_111,
        INVALID = 6'b111_111
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE, I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE
    } format_e;

    //////////////////////////////
    // Instruction word views
    //////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        logic [31:0] raw;
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        b_fmt_t      b;
        u_fmt_t      u;
        j_fmt_t      j;
    } instr_u;

    //////////////////////////////
    // Port bundles
    //////////////////////////////

    typedef struct packed {
        instr_u            instr;
        logic [XLEN-1:0]   pc;
        logic [TAG_W-1:0]  tag;
    } fetch_t;

    typedef struct packed {
        logic [XLEN-1:0]   first_op;
        logic [XLEN-1:0]   second_op;
        logic [XLEN-1:0]   third_op;
        logic [XLEN-1:0]   pc;
        instr_u            instr;
        logic [TAG_W-1:0]  tag;
        op_e               op;
        logic              exception;  // Operation is INVALID
    } issue_t;

endpackage
